// ==== verification/softmax_golden.mem ====
// reps_first_row_score0..score7_expmax_expsum_prob0..prob7, all hex, signed scores
// reps is how often the row is sent in a row, expsum belongs to the last copy
01_1_0_00_04_08_0c_10_14_18_1c_07_00ff_01_02_04_08_10_20_40_80
01_1_1_0c_0c_fc_00_08_0c_04_f0_03_01f9_80_80_08_10_40_80_20_01
01_0_0_24_20_1c_18_14_10_0c_08_09_013e_80_40_20_10_08_04_02_01
01_0_1_04_00_f8_08_ec_04_00_fc_03_02a5_20_10_04_40_00_20_10_08
01_0_0_24_24_24_24_24_24_24_24_09_053e_80_80_80_80_80_80_80_80
01_0_0_30_10_10_10_10_10_10_10_0c_0127_80_00_00_00_00_00_00_00
01_1_2_fb_ff_80_f7_fc_fe_f3_ef_ff_01f8_40_80_00_20_80_80_10_08
01_0_1_14_00_00_00_00_00_00_00_05_0145_80_04_04_04_04_04_04_04
01_0_2_f4_f4_f4_f4_f4_f4_f4_f4_ff_02f8_20_20_20_20_20_20_20_20
01_1_0_80_7f_7c_78_74_70_00_c0_1f_0170_00_80_80_40_20_10_00_00
01_0_3_fc_f8_f4_f0_ec_e8_e4_e0_00_007f_40_20_10_08_04_02_01_00
01_0_3_50_50_50_50_50_50_50_50_14_0400_80_80_80_80_80_80_80_80
01_1_4_14_14_14_14_14_14_14_14_05_0400_80_80_80_80_80_80_80_80
3f_0_4_14_14_14_14_14_14_14_14_05_ffff_80_80_80_80_80_80_80_80
01_0_4_14_14_14_14_14_14_14_14_05_ffff_80_80_80_80_80_80_80_80
01_0_4_18_18_18_18_18_18_18_18_06_83ff_80_80_80_80_80_80_80_80
01_1_f_01_02_03_05_06_07_0b_0d_03_0150_10_10_10_20_20_20_40_80
01_0_1_14_14_10_10_0c_0c_08_08_05_0325_80_80_40_40_20_20_10_10
01_0_f_10_0c_08_04_00_fc_f8_f4_04_01a7_80_40_20_10_08_04_02_01
01_0_2_80_80_80_80_80_80_80_80_ff_02f8_00_00_00_00_00_00_00_00
01_0_0_7c_7c_7c_7c_7c_7c_7c_7c_1f_0570_80_80_80_80_80_80_80_80
01_1_5_7f_80_01_ff_40_bf_3f_c1_1f_0080_80_00_00_00_00_00_00_00
01_0_5_60_64_68_6c_70_74_78_7c_1f_017f_01_02_04_08_10_20_40_80
01_1_6_28_0c_08_28_0c_08_28_0c_0a_0183_80_01_00_80_01_00_80_01
01_0_6_34_34_18_14_34_18_14_34_0d_0232_80_80_01_00_80_01_00_80
01_1_2_00_00_00_00_00_00_00_00_00_0400_80_80_80_80_80_80_80_80
01_0_4_54_54_54_54_54_54_54_54_15_0401_80_80_80_80_80_80_80_80
01_0_f_00_04_08_0c_00_04_08_0c_04_0297_08_10_20_40_08_10_20_40
01_0_7_04_04_04_04_04_04_04_04_01_0400_80_80_80_80_80_80_80_80
01_0_0_7f_7b_77_73_6f_6b_67_63_1f_066f_80_40_20_10_08_04_02_01

// ==== sim.f ====
src/attn_pkg.sv
src/score_scale_max.sv
src/online_softmax_stats.sv
src/online_softmax_top.sv
verification/tb_online_softmax.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the online softmax testbench with verilator
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -f sim.f --top-module tb_online_softmax -o tb_sim &&
    ./obj_dir/tb_sim ||
    { echo "simulation did not pass"; exit 1; }

// ==== verification/tb_online_softmax.sv ====
`timescale 1ns/10ps

module tb_online_softmax
    import attn_pkg::*;
();

    localparam int N_REC      = 30;   // records in the golden file
    localparam int REC_W      = 168;  // 42 hex digits per record
    localparam int CLK_PERIOD = 40;

    logic     I_CLK;
    logic     I_RST_N;
    logic     i_row_vld;
    score_t   i_row_data [N_ELEM];
    row_idx_t i_row_idx;
    logic     i_first;
    logic     o_row_rdy;
    logic     o_res_vld;
    prob_t    o_prob [N_ELEM];
    score_t   o_max;
    sum_t     o_sum;
    row_idx_t o_row_idx;
    logic     i_res_rdy;

    logic [REC_W-1:0] golden [N_REC];
    int seed = 93704;
    int cycle_limit;

    online_softmax_top dut (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .i_row_vld  (i_row_vld),
        .i_row_data (i_row_data),
        .i_row_idx  (i_row_idx),
        .i_first    (i_first),
        .o_row_rdy  (o_row_rdy),
        .o_res_vld  (o_res_vld),
        .o_prob     (o_prob),
        .o_max      (o_max),
        .o_sum      (o_sum),
        .o_row_idx  (o_row_idx),
        .i_res_rdy  (i_res_rdy)
    );

    //////////////////////////////////////////////////
    // golden record fields, element 0 leftmost
    //////////////////////////////////////////////////
    function automatic int reps_field(int r);
        return int'(golden[r][167:160]);
    endfunction

    function automatic logic first_field(int r);
        return golden[r][156];
    endfunction

    function automatic row_idx_t row_field(int r);
        return golden[r][155:152];
    endfunction

    function automatic score_t score_field(int r, int j);
        return golden[r][151-8*j -: 8];
    endfunction

    function automatic score_t max_field(int r);
        return golden[r][87:80];
    endfunction

    function automatic sum_t sum_field(int r);
        return golden[r][79:64];
    endfunction

    function automatic prob_t prob_field(int r, int j);
        return golden[r][63-8*j -: 8];
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_prob(string name, prob_t exp_val, prob_t act_val);
        if (act_val !== exp_val) begin
            $display("error %s expected %0d actual %0d", name, exp_val, act_val);
            $display("test failed");
            $fatal(1, "probability mismatch");
        end
    endtask

    task automatic check_max(string name, score_t exp_val, score_t act_val);
        if (act_val !== exp_val) begin
            $display("error %s expected %0d actual %0d", name, exp_val, act_val);
            $display("test failed");
            $fatal(1, "running max mismatch");
        end
    endtask

    task automatic check_sum(string name, sum_t exp_val, sum_t act_val);
        if (act_val !== exp_val) begin
            $display("error %s expected %0d actual %0d", name, exp_val, act_val);
            $display("test failed");
            $fatal(1, "running sum mismatch");
        end
    endtask

    task automatic check_row(string name, row_idx_t exp_val, row_idx_t act_val);
        if (act_val !== exp_val) begin
            $display("error %s expected %0d actual %0d", name, exp_val, act_val);
            $display("test failed");
            $fatal(1, "row index mismatch");
        end
    endtask

    initial begin
        I_CLK = 1'b0;
        forever #(CLK_PERIOD/2) I_CLK = ~I_CLK;
    end

    //////////////////////////////////////////////////
    // reset and row driver
    //////////////////////////////////////////////////
    initial begin : stimulus
        int   gap;
        logic taken;
        I_RST_N   = 1'b0;
        i_row_vld = 1'b0;
        i_row_idx = '0;
        i_first   = 1'b0;
        i_res_rdy = 1'b0;
        gap       = 0;
        for (int j = 0; j < N_ELEM; j++) begin
            i_row_data[j] = '0;
        end
        $readmemh("verification/softmax_golden.mem", golden);
        repeat (10) @(posedge I_CLK);
        #2;
        I_RST_N = 1'b1;
        for (int r = 0; r < N_REC; r++) begin
            for (int c = 0; c < reps_field(r); c++) begin
                i_row_vld = 1'b1;
                i_row_idx = row_field(r);
                i_first   = first_field(r);
                for (int j = 0; j < N_ELEM; j++) begin
                    i_row_data[j] = score_field(r, j);
                end
                taken = 1'b0;
                while (!taken) begin
                    @(negedge I_CLK);  // ready settled mid cycle
                    taken = o_row_rdy;
                    if (taken) begin
                        gap = $random(seed) & 7;
                    end
                    @(posedge I_CLK);
                end
                #2;
                i_row_vld = 1'b0;
                if (gap > 2) begin
                    gap = 0;  // mostly back to back
                end
                repeat (gap) begin
                    @(posedge I_CLK);
                    #2;
                end
            end
        end
    end

    // random back-pressure, ready about 3 cycles in 4
    initial begin : backpressure
        @(posedge I_RST_N);
        forever begin
            @(posedge I_CLK);
            #2;
            i_res_rdy = (($random(seed) & 3) != 0);
        end
    end

    //////////////////////////////////////////////////
    // result monitor
    //////////////////////////////////////////////////
    initial begin : monitor
        int    out_rec;
        int    out_copy;
        string tag;
        out_rec  = 0;
        out_copy = 0;
        @(posedge I_RST_N);
        while (out_rec < N_REC) begin
            @(negedge I_CLK);
            if (o_res_vld && i_res_rdy) begin  // transfer at the next edge
                tag = $sformatf("rec %0d copy %0d", out_rec, out_copy);
                check_row({tag, " row"}, row_field(out_rec), o_row_idx);
                check_max({tag, " max"}, max_field(out_rec), o_max);
                for (int j = 0; j < N_ELEM; j++) begin
                    check_prob($sformatf("%s prob[%0d]", tag, j), prob_field(out_rec, j),
                               o_prob[j]);
                end
                // sum of a repeated row is known only after its last copy
                if (out_copy == reps_field(out_rec) - 1) begin
                    check_sum({tag, " sum"}, sum_field(out_rec), o_sum);
                    out_rec++;
                    out_copy = 0;
                end else begin
                    out_copy++;
                end
            end
        end
        $display("test passed");
        $finish;
    end

    initial begin : watchdog
        int total;
        int cycle_cnt;
        total     = 0;
        cycle_cnt = 0;
        @(posedge I_RST_N);
        for (int r = 0; r < N_REC; r++) begin
            total += reps_field(r);
        end
        cycle_limit = 20 * total + 200;
        while (cycle_cnt < cycle_limit) begin
            @(posedge I_CLK);
            cycle_cnt++;
        end
        $display("test failed");
        $fatal(1, "timeout after %0d cycles, not all results came out", cycle_limit);
    end

endmodule

// ==== src/online_softmax_top.sv ====
`timescale 1ns/10ps

module online_softmax_top
    import attn_pkg::*;
#(
    parameter int N_ELEM      = attn_pkg::N_ELEM,
    parameter int N_ROWS      = attn_pkg::N_ROWS,
    parameter int SCALE_SHIFT = attn_pkg::SCALE_SHIFT
) (
    input  logic     I_CLK,
    input  logic     I_RST_N,
    // score rows in
    input  logic     i_row_vld,
    input  score_t   i_row_data [N_ELEM],
    input  row_idx_t i_row_idx,
    input  logic     i_first,
    output logic     o_row_rdy,
    // probabilities and statistics out
    output logic     o_res_vld,
    output prob_t    o_prob [N_ELEM],
    output score_t   o_max,
    output sum_t     o_sum,
    output row_idx_t o_row_idx,
    input  logic     i_res_rdy
);

    logic     s1_vld;
    logic     s1_rdy;
    score_t   s1_scaled [N_ELEM];
    score_t   s1_tile_max;
    row_idx_t s1_row_idx;
    logic     s1_first;

    //////////////////////////////////////////////////
    // stage 1 scale and tile max
    //////////////////////////////////////////////////
    score_scale_max #(
        .N_ELEM      (N_ELEM),
        .SCALE_SHIFT (SCALE_SHIFT)
    ) u_score_scale_max (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .i_row_vld  (i_row_vld),
        .i_row_data (i_row_data),
        .i_row_idx  (i_row_idx),
        .i_first    (i_first),
        .i_down_rdy (s1_rdy),
        .o_row_rdy  (o_row_rdy),
        .o_vld      (s1_vld),
        .o_scaled   (s1_scaled),
        .o_tile_max (s1_tile_max),
        .o_row_idx  (s1_row_idx),
        .o_first    (s1_first)
    );

    //////////////////////////////////////////////////
    // stage 2 online softmax statistics
    //////////////////////////////////////////////////
    online_softmax_stats #(
        .N_ELEM (N_ELEM),
        .N_ROWS (N_ROWS)
    ) u_softmax_stats (
        .I_CLK      (I_CLK),
        .I_RST_N    (I_RST_N),
        .i_vld      (s1_vld),
        .i_scaled   (s1_scaled),
        .i_tile_max (s1_tile_max),
        .i_row_idx  (s1_row_idx),
        .i_first    (s1_first),
        .i_res_rdy  (i_res_rdy),
        .o_rdy      (s1_rdy),
        .o_res_vld  (o_res_vld),
        .o_prob     (o_prob),
        .o_max      (o_max),
        .o_sum      (o_sum),
        .o_row_idx  (o_row_idx)
    );

endmodule

// ==== src/online_softmax_stats.sv ====
`timescale 1ns/10ps

module online_softmax_stats
    import attn_pkg::*;
#(
    parameter int N_ELEM = attn_pkg::N_ELEM,
    parameter int N_ROWS = attn_pkg::N_ROWS
) (
    input  logic     I_CLK,
    input  logic     I_RST_N,
    input  logic     i_vld,
    input  score_t   i_scaled [N_ELEM],
    input  score_t   i_tile_max,
    input  row_idx_t i_row_idx,
    input  logic     i_first,
    input  logic     i_res_rdy,
    output logic     o_rdy,
    output logic     o_res_vld,
    output prob_t    o_prob [N_ELEM],
    output score_t   o_max,
    output sum_t     o_sum,
    output row_idx_t o_row_idx
);

    localparam int DIFF_W = SCORE_W + 1;                      // max minus score, never negative
    localparam int ACC_W  = SUM_W + $clog2(N_ELEM + 1) + 1;   // headroom before saturation

    score_t max_mem [N_ROWS];  // running max per query row
    sum_t   sum_mem [N_ROWS];  // running sum per query row

    score_t            old_max;
    sum_t              old_sum;
    score_t            new_max;
    sum_t              new_sum;
    logic [DIFF_W-1:0] max_delta;
    logic [DIFF_W-1:0] elem_diff [N_ELEM];
    prob_t             prob [N_ELEM];
    sum_t              sum_scaled;
    logic [ACC_W-1:0]  sum_raw;
    logic              take;

    //////////////////////////////////////////////////
    // old statistics and new max
    //////////////////////////////////////////////////
    assign old_max = i_first ? SCORE_MIN : max_mem[i_row_idx];  // new sweep starts fresh
    assign old_sum = i_first ? '0 : sum_mem[i_row_idx];
    assign new_max = (i_tile_max > old_max) ? i_tile_max : old_max;

    //////////////////////////////////////////////////
    // base-2 probabilities and rescaled sum
    //////////////////////////////////////////////////
    for (genvar j = 0; j < N_ELEM; j++) begin : g_prob
        assign elem_diff[j] = DIFF_W'(new_max) - DIFF_W'(i_scaled[j]);  // sign-extended
        assign prob[j]      = (elem_diff[j] >= DIFF_W'(8)) ? '0 : (PROB_ONE >> elem_diff[j][2:0]);
    end

    assign max_delta  = DIFF_W'(new_max) - DIFF_W'(old_max);
    // exp(old - new) as a right shift of the old sum
    assign sum_scaled = (max_delta >= DIFF_W'(16)) ? '0 : (old_sum >> max_delta[3:0]);

    always_comb begin
        sum_raw = ACC_W'(sum_scaled);
        for (int j = 0; j < N_ELEM; j++) begin
            sum_raw = sum_raw + ACC_W'(prob[j]);
        end
        if (sum_raw > ACC_W'(SUM_MAX)) begin
            new_sum = SUM_MAX;  // saturate
        end else begin
            new_sum = sum_t'(sum_raw);
        end
    end

    //////////////////////////////////////////////////
    // stat memory and result register
    //////////////////////////////////////////////////
    assign o_rdy = !o_res_vld || i_res_rdy;
    assign take  = i_vld && o_rdy;

    // read and write share the take edge, so the next row sees this update
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            for (int r = 0; r < N_ROWS; r++) begin
                max_mem[r] <= '0;
                sum_mem[r] <= '0;
            end
            o_res_vld <= 1'b0;
        end else begin
            if (take) begin
                max_mem[i_row_idx] <= new_max;
                sum_mem[i_row_idx] <= new_sum;
            end
            if (o_rdy) begin
                o_res_vld <= i_vld;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (take) begin
            o_prob    <= prob;
            o_max     <= new_max;
            o_sum     <= new_sum;
            o_row_idx <= i_row_idx;
        end
    end

    a_row_in_range : assert property (
        @(posedge I_CLK) disable iff (!I_RST_N)
        i_vld |-> (32'(i_row_idx) < N_ROWS)
    );

    // result held until downstream takes it
    a_res_held : assert property (
        @(posedge I_CLK) disable iff (!I_RST_N)
        (o_res_vld && !i_res_rdy) |=> o_res_vld
    );

endmodule

// ==== src/score_scale_max.sv ====
`timescale 1ns/10ps

module score_scale_max
    import attn_pkg::*;
#(
    parameter int N_ELEM      = attn_pkg::N_ELEM,
    parameter int SCALE_SHIFT = attn_pkg::SCALE_SHIFT
) (
    input  logic     I_CLK,
    input  logic     I_RST_N,
    input  logic     i_row_vld,
    input  score_t   i_row_data [N_ELEM],
    input  row_idx_t i_row_idx,
    input  logic     i_first,
    input  logic     i_down_rdy,
    output logic     o_row_rdy,
    output logic     o_vld,
    output score_t   o_scaled [N_ELEM],
    output score_t   o_tile_max,
    output row_idx_t o_row_idx,
    output logic     o_first
);

    localparam int LEVELS = (N_ELEM > 1) ? $clog2(N_ELEM) : 1;
    localparam int WIDTH  = 1 << LEVELS;   // leaves, padded to a power of two

    score_t scaled [N_ELEM];
    score_t cmp_tree [LEVELS+1][WIDTH];
    logic   load;
    logic [N_ELEM*SCORE_W-1:0] scaled_flat;

    //////////////////////////////////////////////////
    // scaling and max tree
    //////////////////////////////////////////////////
    for (genvar j = 0; j < WIDTH; j++) begin : g_leaf
        if (j < N_ELEM) begin : g_real
            assign scaled[j]      = i_row_data[j] >>> SCALE_SHIFT;  // arithmetic, keeps sign
            assign cmp_tree[0][j] = scaled[j];
        end else begin : g_pad
            assign cmp_tree[0][j] = SCORE_MIN;  // pad never wins
        end
    end

    for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
        for (genvar j = 0; j < (WIDTH >> lvl); j++) begin : g_node
            assign cmp_tree[lvl][j] = (cmp_tree[lvl-1][2*j] > cmp_tree[lvl-1][2*j+1]) ?
                                      cmp_tree[lvl-1][2*j] : cmp_tree[lvl-1][2*j+1];
        end
    end

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////
    assign o_row_rdy = !o_vld || i_down_rdy;  // empty or draining
    assign load      = i_row_vld && o_row_rdy;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            o_vld <= 1'b0;
        end else if (o_row_rdy) begin
            o_vld <= i_row_vld;
        end
    end

    always_ff @(posedge I_CLK) begin
        if (load) begin
            o_scaled   <= scaled;
            o_tile_max <= cmp_tree[LEVELS][0];  // root of the tree
            o_row_idx  <= i_row_idx;
            o_first    <= i_first;
        end
    end

    always_comb begin
        for (int j = 0; j < N_ELEM; j++) begin
            scaled_flat[j*SCORE_W +: SCORE_W] = o_scaled[j];
        end
    end

    // a stalled row must not change under the consumer
    a_hold_stable : assert property (
        @(posedge I_CLK) disable iff (!I_RST_N)
        (o_vld && !i_down_rdy) |=> (o_vld && $stable(scaled_flat) && $stable(o_tile_max)
                                    && $stable(o_row_idx) && $stable(o_first))
    );

endmodule

// ==== src/attn_pkg.sv ====
package attn_pkg;

    //////////////////////////////////////////////////
    // tile geometry defaults
    //////////////////////////////////////////////////
    parameter int N_ELEM      = 8;   // scores per row, one key tile
    parameter int N_ROWS      = 16;  // query rows per block
    parameter int SCALE_SHIFT = 2;   // stands in for 1/sqrt(d_k)

    //////////////////////////////////////////////////
    // datapath widths and types
    //////////////////////////////////////////////////
    parameter int SCORE_W = 8;
    parameter int PROB_W  = 8;
    parameter int SUM_W   = 16;
    parameter int ROW_W   = 4;       // covers N_ROWS up to 16

    typedef logic signed [SCORE_W-1:0] score_t;  // score, scaled score, running max
    typedef logic        [PROB_W-1:0]  prob_t;   // 128 at the row maximum
    typedef logic        [SUM_W-1:0]   sum_t;    // running exponent sum
    typedef logic        [ROW_W-1:0]   row_idx_t;

    //////////////////////////////////////////////////
    // constants
    //////////////////////////////////////////////////
    // a fresh key sweep starts from the most negative score, so the
    // first tile max always wins and the old sum is scaled to nothing
    localparam score_t SCORE_MIN = score_t'(-128);
    localparam prob_t  PROB_ONE  = prob_t'(128);   // 2^0 in 1.7 format
    localparam sum_t   SUM_MAX   = '1;             // saturation ceiling

endpackage
